//--- hdl/cos_stage.sv
`timescale 1ns/1ps
`include "dds_settings.svh"

module cos_stage import dds_pkg::*; (
  input  logic         clk,
  input  logic         reset,
  input  beat_phase_t  beat_phases,
  input  logic         phase_valid,
  input  scale_t       scale,
  output logic         stall,
  output beat_sample_t out_data,
  output logic         out_valid,
  input  logic         out_ready
);

  localparam int  LUT_DEPTH = 2 ** `DDS_LUT_ADDR_BITS;
  localparam int  ADDR_LSB  = `DDS_PHASE_BITS - `DDS_LUT_ADDR_BITS;
  localparam real PI        = 3.14159265358979;

  sample_t   cos_lut [LUT_DEPTH];
  lut_addr_t lane_addr [`DDS_LANES];
  sample_t   lut_q [`DDS_LANES];
  logic      lut_valid;

  // entry k is floor(cos(2*pi*k/depth) * (full scale - 0.5) - 0.5).
  function automatic sample_t lut_entry(input int k);
    real angle;
    real amplitude;
    angle     = 2.0 * PI * real'(k) / real'(LUT_DEPTH);
    amplitude = real'(2 ** (`DDS_SAMPLE_WIDTH - 1)) - 0.5;
    return sample_t'(int'($floor($cos(angle) * amplitude - 0.5)));
  endfunction

  initial begin
    for (int k = 0; k < LUT_DEPTH; k++) begin
      cos_lut[k] = lut_entry(k);
    end
  end

  always_comb begin
    for (int i = 0; i < `DDS_LANES; i++) begin
      lane_addr[i] = beat_phases[i*`DDS_PHASE_BITS + ADDR_LSB +: `DDS_LUT_ADDR_BITS];
    end
  end

  assign stall = out_valid && !out_ready; // freezes both stages and the accumulator.

  // ****************************************************************************
  // table read, then scale register
  // ****************************************************************************

  always_ff @(posedge clk) begin
    if (!stall) begin
      for (int i = 0; i < `DDS_LANES; i++) begin
        lut_q[i] <= cos_lut[lane_addr[i]];
        out_data[i*`DDS_SAMPLE_WIDTH +: `DDS_SAMPLE_WIDTH] <= lut_q[i] >>> scale;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      lut_valid <= 1'b0;
      out_valid <= 1'b0;
    end else if (!stall) begin
      lut_valid <= phase_valid;
      out_valid <= lut_valid;
    end
  end

  a_out_hold: assert property (@(posedge clk) disable iff (reset)
    stall |=> out_valid && $stable(out_data));

endmodule

//--- hdl/dds_pkg.sv
`include "dds_settings.svh"

package dds_pkg;

  typedef logic [`DDS_PHASE_BITS-1:0] phase_t;
  typedef logic signed [`DDS_SAMPLE_WIDTH-1:0] sample_t;
  typedef logic [`DDS_LUT_ADDR_BITS-1:0] lut_addr_t;
  typedef logic [`DDS_SCALE_BITS-1:0] scale_t;

  // lane 0 sits in the low bits of both beat types.
  typedef logic [`DDS_LANES*`DDS_PHASE_BITS-1:0] beat_phase_t;
  typedef logic [`DDS_LANES*`DDS_SAMPLE_WIDTH-1:0] beat_sample_t;

  typedef logic [`DDS_AXI_ADDR_BITS-1:0] axil_addr_t;
  typedef logic [`DDS_AXI_DATA_BITS-1:0] axil_data_t;

  typedef enum logic {
    wr_idle,
    wr_resp
  } axil_wr_state_e;

endpackage

//--- hdl/dds_regs.sv
`timescale 1ns/1ps
`include "dds_settings.svh"

module dds_regs import dds_pkg::*; (
  input  logic                           clk,
  input  logic                           reset,
  input  axil_addr_t                     awaddr,
  input  logic                           awvalid,
  output logic                           awready,
  input  axil_data_t                     wdata,
  input  logic [`DDS_AXI_DATA_BITS/8-1:0] wstrb,
  input  logic                           wvalid,
  output logic                           wready,
  output logic [1:0]                     bresp,
  output logic                           bvalid,
  input  logic                           bready,
  input  axil_addr_t                     araddr,
  input  logic                           arvalid,
  output logic                           arready,
  output axil_data_t                     rdata,
  output logic [1:0]                     rresp,
  output logic                           rvalid,
  input  logic                           rready,
  output phase_t                         phase_inc,
  output scale_t                         scale,
  output logic                           enable,
  output logic                           restart
);

  axil_wr_state_e wr_state;
  axil_data_t     wr_current;
  axil_data_t     wr_merged;
  logic           wr_accept;
  logic           rd_accept;

  // current register contents as seen on the bus, zero for unmapped addresses.
  function automatic axil_data_t reg_word(input axil_addr_t addr);
    case (addr)
      `DDS_REG_INC:   return axil_data_t'(phase_inc);
      `DDS_REG_SCALE: return axil_data_t'(scale);
      `DDS_REG_CTRL:  return axil_data_t'(enable);
      default:        return '0;
    endcase
  endfunction

  // ****************************************************************************
  // write channel
  // ****************************************************************************

  assign wr_accept = (wr_state == wr_idle) && awvalid && wvalid;
  assign awready   = wr_accept;
  assign wready    = wr_accept;
  assign bvalid    = (wr_state == wr_resp);
  assign bresp     = 2'b00;

  always_comb begin
    wr_current = reg_word(awaddr);
    for (int b = 0; b < `DDS_AXI_DATA_BITS/8; b++) begin
      wr_merged[b*8 +: 8] = wstrb[b] ? wdata[b*8 +: 8] : wr_current[b*8 +: 8];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_state  <= wr_idle;
      phase_inc <= '0;
      scale     <= '0;
      enable    <= 1'b0;
      restart   <= 1'b0;
    end else begin
      restart <= 1'b0;
      case (wr_state)
        wr_idle: begin
          if (wr_accept) begin
            wr_state <= wr_resp;
            case (awaddr)
              `DDS_REG_INC:   phase_inc <= phase_t'(wr_merged);
              `DDS_REG_SCALE: scale <= scale_t'(wr_merged);
              `DDS_REG_CTRL: begin
                enable  <= wr_merged[0];
                restart <= wr_merged[0] && !enable; // only a 0 to 1 change restarts.
              end
              default: ;
            endcase
          end
        end
        wr_resp: if (bready) wr_state <= wr_idle;
        default: wr_state <= wr_idle;
      endcase
    end
  end

  // ****************************************************************************
  // read channel
  // ****************************************************************************

  assign rd_accept = arvalid && !rvalid;
  assign arready   = rd_accept;
  assign rresp     = 2'b00;

  always_ff @(posedge clk) begin
    if (reset) begin
      rvalid <= 1'b0;
    end else if (rd_accept) begin
      rvalid <= 1'b1;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_accept) rdata <= reg_word(araddr);
  end

  a_bvalid_hold: assert property (@(posedge clk) disable iff (reset)
    bvalid && !bready |=> bvalid);
  a_rvalid_hold: assert property (@(posedge clk) disable iff (reset)
    rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

//--- hdl/dds_settings.svh
`ifndef DDS_SETTINGS_SVH
`define DDS_SETTINGS_SVH

// ****************************************************************************
// datapath widths
// ****************************************************************************

`define DDS_PHASE_BITS     24
`define DDS_LUT_ADDR_BITS  8   // top phase bits address the table.
`define DDS_SAMPLE_WIDTH   16
`define DDS_LANES          4
`define DDS_SCALE_BITS     4

// ****************************************************************************
// register interface
// ****************************************************************************

`define DDS_AXI_ADDR_BITS  4
`define DDS_AXI_DATA_BITS  32

`define DDS_REG_INC        4'h0
`define DDS_REG_SCALE      4'h4
`define DDS_REG_CTRL       4'h8  // bit 0 is the enable.

`endif

//--- hdl/dds_top.sv
`timescale 1ns/1ps
`include "dds_settings.svh"

module dds_top import dds_pkg::*; (
  input  logic                           clk,
  input  logic                           reset,
  input  axil_addr_t                     awaddr,
  input  logic                           awvalid,
  output logic                           awready,
  input  axil_data_t                     wdata,
  input  logic [`DDS_AXI_DATA_BITS/8-1:0] wstrb,
  input  logic                           wvalid,
  output logic                           wready,
  output logic [1:0]                     bresp,
  output logic                           bvalid,
  input  logic                           bready,
  input  axil_addr_t                     araddr,
  input  logic                           arvalid,
  output logic                           arready,
  output axil_data_t                     rdata,
  output logic [1:0]                     rresp,
  output logic                           rvalid,
  input  logic                           rready,
  output beat_sample_t                   out_data,
  output logic                           out_valid,
  input  logic                           out_ready
);

  phase_t      phase_inc;
  scale_t      scale;
  logic        enable;
  logic        restart;
  beat_phase_t beat_phases;
  logic        phase_valid;
  logic        stall;

  dds_regs u_regs (
    .clk, .reset,
    .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
    .bresp, .bvalid, .bready,
    .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
    .phase_inc, .scale, .enable, .restart
  );

  phase_accumulator u_accum (
    .clk, .reset,
    .phase_inc, .enable, .restart, .stall,
    .beat_phases, .phase_valid
  );

  cos_stage u_cos (
    .clk, .reset,
    .beat_phases, .phase_valid, .scale, .stall,
    .out_data, .out_valid, .out_ready
  );

endmodule

//--- hdl/phase_accumulator.sv
`timescale 1ns/1ps
`include "dds_settings.svh"

module phase_accumulator import dds_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  phase_t      phase_inc,
  input  logic        enable,
  input  logic        restart,
  input  logic        stall,
  output beat_phase_t beat_phases,
  output logic        phase_valid
);

  phase_t phase;
  phase_t lane_offset [`DDS_LANES];
  phase_t lane_step;
  logic   hold;

  assign hold = phase_valid && stall; // the presented beat waits downstream.

  // offsets follow the increment but freeze while a beat is held.
  always_ff @(posedge clk) begin
    if (!hold) begin
      for (int i = 0; i < `DDS_LANES; i++) begin
        lane_offset[i] <= phase_t'(phase_inc * phase_t'(i));
      end
      lane_step <= phase_t'(phase_inc * phase_t'(`DDS_LANES));
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      phase       <= '0;
      phase_valid <= 1'b0;
    end else begin
      if (restart) begin
        phase <= '0;
      end else if (phase_valid && !stall) begin
        phase <= phase + lane_step; // wraps modulo the phase width.
      end
      if (!enable) begin
        phase_valid <= 1'b0;
      end else if (!stall) begin
        phase_valid <= 1'b1;
      end
    end
  end

  always_comb begin
    for (int i = 0; i < `DDS_LANES; i++) begin
      beat_phases[i*`DDS_PHASE_BITS +: `DDS_PHASE_BITS] = phase + lane_offset[i];
    end
  end

  // restart only follows a disabled cycle, so it never meets a held beat.
  a_beat_hold: assert property (@(posedge clk) disable iff (reset)
    phase_valid && stall |=> $stable(beat_phases));

endmodule

//--- list.f
+incdir+hdl
hdl/dds_pkg.sv
hdl/dds_regs.sv
hdl/phase_accumulator.sv
hdl/cos_stage.sv
hdl/dds_top.sv
sim/dds_tb.sv

//--- run.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal -f list.f --top-module dds_tb -o dds_sim \
  && ./obj_dir/dds_sim | tee sim.log \
  || { echo "build or run failed"; exit 1; }

grep -q "Simulation finished: PASS" sim.log \
  && echo "result: pass" \
  || { echo "result: fail"; exit 1; }

//--- sim/dds_tb.sv
`timescale 1ns/1ps
`include "dds_settings.svh"

module dds_tb import dds_pkg::*; ();

  localparam int TONES          = 10;
  localparam int STEADY_TONES   = 6;  // the remaining tones run with random back-pressure.
  localparam int BEATS_PER_TONE = 200;
  localparam int WATCHDOG_NS    = TONES * BEATS_PER_TONE * 40 + 20000;
  localparam int LUT_DEPTH      = 2 ** `DDS_LUT_ADDR_BITS;

  logic                            clk;
  logic                            reset;
  axil_addr_t                      awaddr;
  logic                            awvalid;
  logic                            awready;
  axil_data_t                      wdata;
  logic [`DDS_AXI_DATA_BITS/8-1:0] wstrb;
  logic                            wvalid;
  logic                            wready;
  logic [1:0]                      bresp;
  logic                            bvalid;
  logic                            bready;
  axil_addr_t                      araddr;
  logic                            arvalid;
  logic                            arready;
  axil_data_t                      rdata;
  logic [1:0]                      rresp;
  logic                            rvalid;
  logic                            rready;
  beat_sample_t                    out_data;
  logic                            out_valid;
  logic                            out_ready;

  sample_t     cos_table [LUT_DEPTH];
  phase_t      model_phase;
  phase_t      model_inc;
  scale_t      model_scale;
  int          beat_count;
  int          errors;
  int          cycle;
  int          bvalid_cycle;
  logic        random_ready;
  logic        expect_idle;
  logic [31:0] rng;
  logic [31:0] ready_rng;

  dds_top DUT (
    .clk, .reset,
    .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
    .bresp, .bvalid, .bready,
    .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
    .out_data, .out_valid, .out_ready
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  // ****************************************************************************
  // AXI4-Lite master
  // ****************************************************************************

  task automatic axil_write(input axil_addr_t addr, input axil_data_t data);
    @(negedge clk);
    awaddr  = addr;
    wdata   = data;
    wstrb   = '1;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    bready  = 1'b1;
    @(posedge clk);
    while (!awready) @(posedge clk);  // the write is taken at the edge where awready is high.
    assert (wready) else begin
      errors++;
      $display("[FAIL] wready: expected %h, got %h", 1'b1, wready);
    end
    @(negedge clk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    while (!bvalid) @(negedge clk);
    bvalid_cycle = cycle;
    assert (bresp == 2'b00) else begin
      errors++;
      $display("[FAIL] bresp: expected %h, got %h", 2'b00, bresp);
    end
    @(negedge clk);
    bready = 1'b0;
  endtask

  task automatic axil_read(input axil_addr_t addr, output axil_data_t data);
    @(negedge clk);
    araddr  = addr;
    arvalid = 1'b1;
    @(posedge clk);
    while (!arready) @(posedge clk);
    @(negedge clk);
    arvalid = 1'b0;
    while (!rvalid) @(negedge clk);
    data   = rdata;
    rready = 1'b1;
    assert (rresp == 2'b00) else begin
      errors++;
      $display("[FAIL] rresp: expected %h, got %h", 2'b00, rresp);
    end
    @(negedge clk);
    rready = 1'b0;
  endtask

  task automatic check_read(input axil_addr_t addr, input axil_data_t expected, input string name);
    axil_data_t got;
    axil_read(addr, got);
    assert (got == expected) else begin
      errors++;
      $display("[FAIL] rdata (%s): expected %h, got %h", name, expected, got);
    end
  endtask

  // ****************************************************************************
  // reference model and output monitor
  // ****************************************************************************

  task automatic check_beat(input beat_sample_t got);
    phase_t  lane_phase;
    sample_t expected;
    sample_t actual;
    for (int i = 0; i < `DDS_LANES; i++) begin
      lane_phase = model_phase + phase_t'(i) * model_inc;
      expected   = cos_table[lane_phase[`DDS_PHASE_BITS-1 -: `DDS_LUT_ADDR_BITS]] >>> model_scale;
      actual     = got[i*`DDS_SAMPLE_WIDTH +: `DDS_SAMPLE_WIDTH];
      assert (actual == expected) else begin
        errors++;
        $display("[FAIL] out_data lane %0d beat %0d: expected %h, got %h",
                 i, beat_count, expected, actual);
      end
    end
  endtask

  initial begin
    logic         ready_now;
    logic         held;
    beat_sample_t held_data;
    out_ready = 1'b1;
    held      = 1'b0;
    held_data = '0;
    forever begin
      @(negedge clk);
      if (held) begin
        assert (out_valid && out_data == held_data) else begin
          errors++;
          $display("[FAIL] out_data under stall: expected %h, got %h (out_valid %h)",
                   held_data, out_data, out_valid);
        end
      end
      if (expect_idle) begin
        assert (!out_valid) else begin
          errors++;
          $display("out_valid went high while the tone was disabled");
        end
      end
      if (random_ready) begin
        ready_rng = xorshift32(ready_rng);
        ready_now = ready_rng[31];
      end else begin
        ready_now = 1'b1;
      end
      out_ready = ready_now;  // this value is sampled at the next rising edge.
      held      = out_valid && !ready_now;
      held_data = out_data;
      if (out_valid && ready_now) begin
        check_beat(out_data);
        model_phase = model_phase + phase_t'(`DDS_LANES) * model_inc;
        beat_count++;
      end
    end
  end

  // ****************************************************************************
  // tone control
  // ****************************************************************************

  task automatic start_tone(input phase_t inc, input scale_t scl);
    axil_write(`DDS_REG_INC, axil_data_t'(inc));
    axil_write(`DDS_REG_SCALE, axil_data_t'(scl));
    model_inc   = inc;
    model_scale = scl;
    model_phase = '0;  // the enable edge restarts the tone at phase zero.
    beat_count  = 0;
    expect_idle = 1'b0;
    axil_write(`DDS_REG_CTRL, 32'h1);
    while (!out_valid) @(negedge clk);
    assert (cycle - bvalid_cycle == 3) else begin
      errors++;
      $display("first beat came %0d cycles after bvalid instead of 3", cycle - bvalid_cycle);
    end
  endtask

  task automatic stop_tone();
    random_ready = 1'b0;
    axil_write(`DDS_REG_CTRL, 32'h0);
    while (out_valid && cycle - bvalid_cycle < 10) @(negedge clk);
    assert (!out_valid && cycle - bvalid_cycle <= 4) else begin
      errors++;
      $display("pipeline did not drain within 4 cycles after enable was cleared");
    end
    expect_idle = 1'b1;
  endtask

  initial begin
    axil_data_t value;
    phase_t     inc;
    scale_t     scl;
    int         gap;
    rng          = 32'd47;
    ready_rng    = 32'd47;
    errors       = 0;
    random_ready = 1'b0;
    expect_idle  = 1'b0;
    reset        = 1'b1;
    awaddr       = '0;
    awvalid      = 1'b0;
    wdata        = '0;
    wstrb        = '0;
    wvalid       = 1'b0;
    bready       = 1'b0;
    araddr       = '0;
    arvalid      = 1'b0;
    rready       = 1'b0;
    for (int k = 0; k < LUT_DEPTH; k++) begin
      cos_table[k] = sample_t'(int'($floor($cos(2.0 * 3.141592653589793 * k / LUT_DEPTH)
                     * (real'(1 << (`DDS_SAMPLE_WIDTH - 1)) - 0.5) - 0.5)));
    end
    repeat (2) @(negedge clk);
    reset       = 1'b0;
    expect_idle = 1'b1;

    // register readback, with enable kept low.
    for (int n = 0; n < 4; n++) begin
      value = next_rand();
      axil_write(`DDS_REG_INC, value);
      check_read(`DDS_REG_INC, value & 32'h00ff_ffff, "phase_inc");
      value = next_rand();
      axil_write(`DDS_REG_SCALE, value);
      check_read(`DDS_REG_SCALE, value & 32'h0000_000f, "scale");
      value = next_rand() & ~32'h1;
      axil_write(`DDS_REG_CTRL, value);
      check_read(`DDS_REG_CTRL, 32'h0, "enable");
    end
    check_read(4'hc, 32'h0, "unmapped");

    for (int t = 0; t < TONES; t++) begin
      inc = phase_t'(next_rand());
      scl = scale_t'(next_rand());
      @(posedge clk);
      random_ready = (t >= STEADY_TONES);
      start_tone(inc, scl);
      check_read(`DDS_REG_CTRL, 32'h1, "enable");
      while (beat_count < BEATS_PER_TONE) @(posedge clk);
      stop_tone();
      gap = int'(next_rand() % 32'd16) + 4;
      repeat (gap) @(negedge clk);
    end

    $display("checks done, %0d errors", errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, %0d errors so far", WATCHDOG_NS, errors);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule
